/* source/dcache_pkg.sv */
package dcache_pkg;

    // Cache geometry
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int BLOCK_W    = 128;
    localparam int WAYS       = 2;
    localparam int SETS       = 16;
    localparam int OFFSET_W   = 4;
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = 24;
    localparam int WAY_W      = 1;

    // Byte offset inside a word, and the word select inside a block
    localparam int BYTE_OFF_W = 2;
    localparam int WORD_SEL_W = OFFSET_W - BYTE_OFF_W;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [BLOCK_W-1:0]    block_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [WAY_W-1:0]      way_t;
    typedef logic [WAYS-1:0]       way_mask_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        RESPOND,
        WB_REQ,
        FILL_REQ,
        FILL_WAIT
    } ctrl_state_t;

    function automatic tag_t addr_tag(addr_t addr);
        return addr[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic index_t addr_index(addr_t addr);
        return addr[OFFSET_W +: INDEX_W];
    endfunction

    function automatic word_sel_t addr_word(addr_t addr);
        return addr[BYTE_OFF_W +: WORD_SEL_W];
    endfunction

    function automatic addr_t block_addr(tag_t tag, index_t index);
        return {tag, index, {OFFSET_W{1'b0}}};
    endfunction

endpackage

/* source/way_select.sv */
`timescale 1ns/1ps

module way_select import dcache_pkg::*; (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  tag_t [WAYS-1:0] tag_i,
    input  way_mask_t       valid_i,
    input  tag_t            lookup_tag_i,
    input  logic            advance_i,
    output logic            hit_o,
    output way_t            hit_way_o,
    output way_t            victim_way_o
);

    way_t rr_q;

    always_comb begin
        hit_o     = 1'b0;
        hit_way_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_i[w] && tag_i[w] == lookup_tag_i) begin
                hit_o     = 1'b1;
                hit_way_o = way_t'(w);
            end
        end
    end

    // Lowest invalid way wins, round robin only when the set is full
    always_comb begin
        victim_way_o = rr_q;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!valid_i[w]) begin
                victim_way_o = way_t'(w);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rr_q <= '0;
        end else if (advance_i) begin
            rr_q <= (rr_q == way_t'(WAYS - 1)) ? '0 : rr_q + 1'b1;
        end
    end

endmodule

/* source/dcache_arrays.sv */
`timescale 1ns/1ps

module dcache_arrays import dcache_pkg::*; (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  index_t            index_i,
    input  way_mask_t         we_i,
    input  tag_t              wtag_i,
    input  block_t            wblock_i,
    input  logic              dirty_i,
    output tag_t   [WAYS-1:0] tag_o,
    output block_t [WAYS-1:0] block_o,
    output way_mask_t         valid_o,
    output way_mask_t         dirty_o
);

    tag_t      tag_mem   [WAYS][SETS];
    block_t    block_mem [WAYS][SETS];
    way_mask_t valid_q   [SETS];
    way_mask_t dirty_q   [SETS];

    // Tag and data storage with a registered read port
    // Write-first, so the read right after a fill returns the new block
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < WAYS; w++) begin
            if (we_i[w]) begin
                tag_mem[w][index_i]   <= wtag_i;
                block_mem[w][index_i] <= wblock_i;
                tag_o[w]              <= wtag_i;
                block_o[w]            <= wblock_i;
            end else begin
                tag_o[w]   <= tag_mem[w][index_i];
                block_o[w] <= block_mem[w][index_i];
            end
        end
    end

    // Valid and dirty flags per set and way
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            valid_o <= '0;
            dirty_o <= '0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (we_i[w]) begin
                    valid_q[index_i][w] <= 1'b1;
                    dirty_q[index_i][w] <= dirty_i;
                    valid_o[w]          <= 1'b1;
                    dirty_o[w]          <= dirty_i;
                end else begin
                    valid_o[w] <= valid_q[index_i][w];
                    dirty_o[w] <= dirty_q[index_i][w];
                end
            end
        end
    end

endmodule

/* source/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic              clk_i,
    input  logic              rstn_i,

    input  logic              req_valid_i,
    input  logic              req_write_i,
    input  addr_t             req_addr_i,
    input  word_t             req_wdata_i,
    input  logic              rsp_ready_i,

    input  logic              mem_req_ready_i,
    input  logic              mem_rsp_valid_i,
    input  block_t            mem_rsp_data_i,

    input  tag_t   [WAYS-1:0] rd_tag_i,
    input  block_t [WAYS-1:0] rd_block_i,
    input  way_mask_t         rd_valid_i,
    input  way_mask_t         rd_dirty_i,

    input  logic              hit_i,
    input  way_t              hit_way_i,
    input  way_t              victim_way_i,

    output logic              req_ready_o,
    output logic              rsp_valid_o,
    output word_t             rsp_rdata_o,

    output logic              mem_req_valid_o,
    output logic              mem_req_write_o,
    output addr_t             mem_req_addr_o,
    output block_t            mem_req_wdata_o,
    output logic              mem_rsp_ready_o,

    output index_t            arr_index_o,
    output way_mask_t         arr_we_o,
    output tag_t              arr_wtag_o,
    output block_t            arr_wblock_o,
    output logic              arr_dirty_o,
    output tag_t              lookup_tag_o,
    output logic              advance_o
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    addr_t  req_addr_q;
    logic   req_write_q;
    word_t  req_wdata_q;
    way_t   victim_q;
    word_t  rsp_rdata_q;
    logic   mem_write_q;
    addr_t  mem_addr_q;
    block_t mem_wdata_q;

    logic   victim_dirty;
    addr_t  fill_addr;
    word_t  hit_word;
    block_t merged_block;
    logic   fill_done;

    assign victim_dirty = rd_valid_i[victim_way_i] & rd_dirty_i[victim_way_i];
    assign fill_addr    = block_addr(addr_tag(req_addr_q), addr_index(req_addr_q));
    assign hit_word     = rd_block_i[hit_way_i][addr_word(req_addr_q)*DATA_W +: DATA_W];
    assign fill_done    = (state_q == FILL_WAIT) && mem_rsp_valid_i;

    // Store word replaces one slot of the hit block
    always_comb begin
        merged_block = rd_block_i[hit_way_i];
        merged_block[addr_word(req_addr_q)*DATA_W +: DATA_W] = req_wdata_q;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit_i) begin
                    state_d = req_write_q ? IDLE : RESPOND;
                end else if (victim_dirty) begin
                    state_d = WB_REQ;
                end else begin
                    state_d = FILL_REQ;
                end
            end
            RESPOND: begin
                if (rsp_ready_i) begin
                    state_d = IDLE;
                end
            end
            WB_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = FILL_REQ;
                end
            end
            FILL_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                // Back to LOOKUP, which now hits on the installed block
                if (mem_rsp_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && req_valid_i) begin
            req_addr_q  <= req_addr_i;
            req_write_q <= req_write_i;
            req_wdata_q <= req_wdata_i;
        end
        if (state_q == LOOKUP) begin
            if (hit_i && !req_write_q) begin
                rsp_rdata_q <= hit_word;
            end else if (!hit_i) begin
                victim_q <= victim_way_i;
                if (victim_dirty) begin
                    mem_write_q <= 1'b1;
                    mem_addr_q  <= block_addr(rd_tag_i[victim_way_i], addr_index(req_addr_q));
                    mem_wdata_q <= rd_block_i[victim_way_i];
                end else begin
                    mem_write_q <= 1'b0;
                    mem_addr_q  <= fill_addr;
                end
            end
        end
        // Write-back accepted, turn the request into the fill
        if (state_q == WB_REQ && mem_req_ready_i) begin
            mem_write_q <= 1'b0;
            mem_addr_q  <= fill_addr;
        end
    end

    always_comb begin
        arr_we_o = '0;
        if (state_q == LOOKUP && hit_i && req_write_q) begin
            arr_we_o[hit_way_i] = 1'b1;
        end
        if (fill_done) begin
            arr_we_o[victim_q] = 1'b1;
        end
    end

    // Index comes straight from the port in IDLE so the read lands at acceptance
    assign arr_index_o  = (state_q == IDLE) ? addr_index(req_addr_i) : addr_index(req_addr_q);
    assign arr_wtag_o   = addr_tag(req_addr_q);
    assign arr_wblock_o = (state_q == LOOKUP) ? merged_block : mem_rsp_data_i;
    assign arr_dirty_o  = (state_q == LOOKUP);
    assign lookup_tag_o = addr_tag(req_addr_q);
    assign advance_o    = fill_done;

    assign req_ready_o     = (state_q == IDLE);
    assign rsp_valid_o     = (state_q == RESPOND);
    assign rsp_rdata_o     = rsp_rdata_q;
    assign mem_req_valid_o = (state_q == WB_REQ) || (state_q == FILL_REQ);
    assign mem_req_write_o = mem_write_q;
    assign mem_req_addr_o  = mem_addr_q;
    assign mem_req_wdata_o = mem_wdata_q;
    assign mem_rsp_ready_o = (state_q == FILL_WAIT);

endmodule

/* source/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic   clk_i,
    input  logic   rstn_i,

    // Load/store port
    input  logic   req_valid_i,
    input  logic   req_write_i,
    input  addr_t  req_addr_i,
    input  word_t  req_wdata_i,
    output logic   req_ready_o,
    output logic   rsp_valid_o,
    output word_t  rsp_rdata_o,
    input  logic   rsp_ready_i,

    // Block-wide memory bus
    output logic   mem_req_valid_o,
    output logic   mem_req_write_o,
    output addr_t  mem_req_addr_o,
    output block_t mem_req_wdata_o,
    input  logic   mem_req_ready_i,
    input  logic   mem_rsp_valid_i,
    input  block_t mem_rsp_data_i,
    output logic   mem_rsp_ready_o
);

    index_t              arr_index;
    way_mask_t           arr_we;
    tag_t                arr_wtag;
    block_t              arr_wblock;
    logic                arr_dirty;
    tag_t   [WAYS-1:0]   rd_tag;
    block_t [WAYS-1:0]   rd_block;
    way_mask_t           rd_valid;
    way_mask_t           rd_dirty;
    tag_t                lookup_tag;
    logic                hit;
    way_t                hit_way;
    way_t                victim_way;
    logic                advance;

    dcache_ctrl dcache_ctrl_i (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .req_valid_i     (req_valid_i),
        .req_write_i     (req_write_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .rsp_ready_i     (rsp_ready_i),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_data_i  (mem_rsp_data_i),
        .rd_tag_i        (rd_tag),
        .rd_block_i      (rd_block),
        .rd_valid_i      (rd_valid),
        .rd_dirty_i      (rd_dirty),
        .hit_i           (hit),
        .hit_way_i       (hit_way),
        .victim_way_i    (victim_way),
        .req_ready_o     (req_ready_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_rdata_o     (rsp_rdata_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_write_o (mem_req_write_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_wdata_o (mem_req_wdata_o),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .arr_index_o     (arr_index),
        .arr_we_o        (arr_we),
        .arr_wtag_o      (arr_wtag),
        .arr_wblock_o    (arr_wblock),
        .arr_dirty_o     (arr_dirty),
        .lookup_tag_o    (lookup_tag),
        .advance_o       (advance)
    );

    dcache_arrays dcache_arrays_i (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .index_i  (arr_index),
        .we_i     (arr_we),
        .wtag_i   (arr_wtag),
        .wblock_i (arr_wblock),
        .dirty_i  (arr_dirty),
        .tag_o    (rd_tag),
        .block_o  (rd_block),
        .valid_o  (rd_valid),
        .dirty_o  (rd_dirty)
    );

    way_select way_select_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .tag_i        (rd_tag),
        .valid_i      (rd_valid),
        .lookup_tag_i (lookup_tag),
        .advance_i    (advance),
        .hit_o        (hit),
        .hit_way_o    (hit_way),
        .victim_way_o (victim_way)
    );

endmodule

/* testbench/dcache_assert.sv */
`timescale 1ns/1ps

module dcache_assert import dcache_pkg::*; (
    input logic   clk_i,
    input logic   rstn_i,
    input logic   req_ready_o,
    input logic   rsp_valid_o,
    input word_t  rsp_rdata_o,
    input logic   rsp_ready_i,
    input logic   mem_req_valid_o,
    input logic   mem_req_write_o,
    input addr_t  mem_req_addr_o,
    input block_t mem_req_wdata_o,
    input logic   mem_req_ready_i,
    input logic   mem_rsp_ready_o
);

    int unsigned error_count = 0;

    // Covers every reset cycle and the first cycle after reset
    reset_idle: assert property (@(posedge clk_i)
        !rstn_i |=> (!rsp_valid_o && !mem_req_valid_o && !mem_rsp_ready_o && req_ready_o))
    else begin
        $error("port outputs are not idle during or right after reset");
        error_count++;
    end

    rsp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_rdata_o)))
    else begin
        $error("read response changed while rsp_ready_i was low");
        error_count++;
    end

    mem_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (mem_req_valid_o && !mem_req_ready_i) |=>
            (mem_req_valid_o && $stable(mem_req_write_o) && $stable(mem_req_addr_o)
             && $stable(mem_req_wdata_o)))
    else begin
        $error("memory request changed while mem_req_ready_i was low");
        error_count++;
    end

    mem_req_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_valid_o |-> (mem_req_addr_o[OFFSET_W-1:0] == '0))
    else begin
        $error("memory request address is not block aligned");
        error_count++;
    end

endmodule

bind dcache_top dcache_assert dcache_assert_i (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .req_ready_o     (req_ready_o),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_rdata_o     (rsp_rdata_o),
    .rsp_ready_i     (rsp_ready_i),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_write_o (mem_req_write_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_wdata_o (mem_req_wdata_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_ready_o (mem_rsp_ready_o)
);

/* testbench/tb_mem.sv */
`timescale 1ns/1ps

module tb_mem import dcache_pkg::*; #(
    parameter int SEED = 84206
) (
    input  logic   clk_i,
    input  logic   rstn_i,
    input  logic   req_valid_i,
    input  logic   req_write_i,
    input  addr_t  req_addr_i,
    input  block_t req_wdata_i,
    output logic   req_ready_o,
    output logic   rsp_valid_o,
    output block_t rsp_data_o,
    input  logic   rsp_ready_i
);

    block_t store [addr_t];
    int     seed = SEED;
    logic   fill_pending = 1'b0;
    addr_t  fill_addr = '0;
    logic   in_reset = 1'b1;

    // Blocks never written back hold the address pattern
    function automatic block_t read_block(addr_t addr);
        block_t blk;
        if (store.exists(addr)) begin
            blk = store[addr];
        end else begin
            for (int i = 0; i < 4; i++) begin
                blk[i*DATA_W +: DATA_W] = (addr + addr_t'(4 * i)) ^ 32'h5A5A0000;
            end
        end
        return blk;
    endfunction

    initial begin
        req_ready_o = 1'b0;
        rsp_valid_o = 1'b0;
        rsp_data_o  = '0;
    end

    always @(posedge clk_i) begin
        in_reset = !rstn_i;
        if (rsp_valid_o && rsp_ready_i) begin
            fill_pending = 1'b0;
        end
        if (req_valid_i && req_ready_o) begin
            if (req_write_i) begin
                store[req_addr_i] = req_wdata_i;
            end else begin
                fill_pending = 1'b1;
                fill_addr    = req_addr_i;
            end
        end
        #1;
        // No new request while a fill is still owed
        req_ready_o = !in_reset && !fill_pending && ($random(seed) % 4 != 0);
        rsp_valid_o = fill_pending && ($random(seed) % 3 != 0);
        rsp_data_o  = fill_pending ? read_block(fill_addr) : '0;
    end

endmodule

/* testbench/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

    localparam int SEED    = 84206;
    localparam int TIMEOUT = 200;

    logic   clk_i = 1'b0;
    logic   rstn_i;
    logic   req_valid_i;
    logic   req_write_i;
    addr_t  req_addr_i;
    word_t  req_wdata_i;
    logic   req_ready_o;
    logic   rsp_valid_o;
    word_t  rsp_rdata_o;
    logic   rsp_ready_i;
    logic   mem_req_valid_o;
    logic   mem_req_write_o;
    addr_t  mem_req_addr_o;
    block_t mem_req_wdata_o;
    logic   mem_req_ready_i;
    logic   mem_rsp_valid_i;
    block_t mem_rsp_data_i;
    logic   mem_rsp_ready_o;

    word_t  shadow [addr_t];
    int     seed = SEED;
    int     mem_req_count = 0;
    int     fill_count = 0;
    int     wb_count = 0;
    addr_t  last_wb_addr = '0;

    always #5 clk_i = ~clk_i;

    dcache_top dcache_top_i (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .req_valid_i     (req_valid_i),
        .req_write_i     (req_write_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .req_ready_o     (req_ready_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_rdata_o     (rsp_rdata_o),
        .rsp_ready_i     (rsp_ready_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_write_o (mem_req_write_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_wdata_o (mem_req_wdata_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_data_i  (mem_rsp_data_i),
        .mem_rsp_ready_o (mem_rsp_ready_o)
    );

    tb_mem #(.SEED(SEED)) tb_mem_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid_i (mem_req_valid_o),
        .req_write_i (mem_req_write_o),
        .req_addr_i  (mem_req_addr_o),
        .req_wdata_i (mem_req_wdata_o),
        .req_ready_o (mem_req_ready_i),
        .rsp_valid_o (mem_rsp_valid_i),
        .rsp_data_o  (mem_rsp_data_i),
        .rsp_ready_i (mem_rsp_ready_o)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_equal(input string name, input word_t got, input word_t exp);
        assert (got == exp) else begin
            abort_run($sformatf("FAIL %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    function automatic word_t expected_word(addr_t addr);
        word_t value;
        if (shadow.exists(addr)) begin
            value = shadow[addr];
        end else begin
            value = addr ^ 32'h5A5A0000;
        end
        return value;
    endfunction

    // Latency counts edges from the handshake cycle to rsp_valid_o or req_ready_o
    task automatic port_access(input logic write, input addr_t addr, input word_t wdata,
                               output word_t rdata, output int latency);
        int waited;
        int stall;
        waited      = 0;
        rdata       = wdata;
        req_valid_i = 1'b1;
        req_write_i = write;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        while (!req_ready_o) begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("timeout while waiting for the cache to accept a request");
            end
        end
        next_cycle();
        req_valid_i = 1'b0;
        latency     = 1;
        if (write) begin
            shadow[addr] = wdata;
        end
        while (write ? !req_ready_o : !rsp_valid_o) begin
            next_cycle();
            latency++;
            if (latency > TIMEOUT) begin
                abort_run("timeout while waiting for the cache to finish an access");
            end
        end
        if (!write) begin
            stall = $random(seed) & 3;
            repeat (stall) next_cycle();
            rsp_ready_i = 1'b1;
            rdata       = rsp_rdata_o;
            next_cycle();
            rsp_ready_i = 1'b0;
        end
    endtask

    task automatic read_check(input addr_t addr, output int latency);
        word_t rdata;
        port_access(1'b0, addr, '0, rdata, latency);
        check_equal("rsp_rdata_o", rdata, expected_word(addr));
    endtask

    task automatic write_word(input addr_t addr, input word_t data);
        word_t unused;
        int    latency;
        port_access(1'b1, addr, data, unused, latency);
    endtask

    always @(posedge clk_i) begin
        if (rstn_i && mem_req_valid_o && mem_req_ready_i) begin
            mem_req_count++;
            if (mem_req_write_o) begin
                wb_count++;
                last_wb_addr = mem_req_addr_o;
            end else begin
                fill_count++;
            end
        end
    end

    always @(negedge clk_i) begin
        if (dcache_top_i.dcache_assert_i.error_count != 0) begin
            abort_run("a bound assertion on the DUT ports failed");
        end
    end

    initial begin
        int    lat;
        int    reqs_before;
        int    wb_before;
        int    rnd;
        addr_t victim;
        addr_t addr;
        rstn_i      = 1'b0;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        rsp_ready_i = 1'b0;
        repeat (10) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        next_cycle();

        // Read miss, then a hit in the same block
        read_check(32'h0000_1000, lat);
        reqs_before = mem_req_count;
        read_check(32'h0000_1004, lat);
        check_equal("memory request count", word_t'(mem_req_count), word_t'(reqs_before));
        check_equal("read hit latency", word_t'(lat), 32'd2);

        // Writes to a cached and an uncached block
        write_word(32'h0000_1008, 32'hCAFE_0001);
        write_word(32'h0000_2040, 32'hCAFE_0002);
        read_check(32'h0000_1008, lat);
        read_check(32'h0000_2040, lat);
        read_check(32'h0000_2044, lat);

        // Set 5 fills way 0, then way 1, then the round-robin counter picks
        write_word(32'h0001_0050, 32'hD1D1_0001);
        write_word(32'h0002_0054, 32'hD1D1_0002);
        wb_before = wb_count;
        victim    = (fill_count % 2 == 0) ? 32'h0001_0050 : 32'h0002_0050;
        write_word(32'h0003_0058, 32'hD1D1_0003);
        check_equal("write-back count", word_t'(wb_count), word_t'(wb_before + 1));
        check_equal("mem_req_addr_o", last_wb_addr, victim);
        read_check(32'h0001_0050, lat);
        read_check(32'h0002_0054, lat);
        read_check(32'h0003_0058, lat);

        // Four tags over four sets keep the ways under pressure
        for (int i = 0; i < 80; i++) begin
            rnd  = $random(seed);
            addr = 32'h0004_0000 | (addr_t'(rnd) & 32'h0000_033C);
            if (rnd[20]) begin
                write_word(addr, $random(seed));
            end else begin
                read_check(addr, lat);
            end
        end

        next_cycle();
        if (dcache_top_i.dcache_assert_i.error_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            abort_run("bound assertions reported errors");
        end
    end

endmodule

/* flist.f */
source/dcache_pkg.sv
source/way_select.sv
source/dcache_arrays.sv
source/dcache_ctrl.sv
source/dcache_top.sv
testbench/dcache_assert.sv
testbench/tb_mem.sv
testbench/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and decide the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module dcache_tb -f flist.f > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vdcache_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && { echo "Run failed"; exit 1; } \
    || { echo "Run finished without failure"; exit 0; }
